// File: verilog/vdf_consts.svh
`ifndef VDF_CONSTS_SVH
`define VDF_CONSTS_SVH

// Operand geometry
`define LIMB_BITS    16
`define NUM_LIMBS    4
`define OPERAND_BITS 64

// Pseudo-Mersenne modulus 2^64 - 59
`define MOD_P        64'hFFFF_FFFF_FFFF_FFC5

// 2^64 mod P, the weight a high half picks up when folded down
`define FOLD_C       59

`define COUNT_BITS   16   // Width of the squaring count

`endif

// File: verilog/vdf_pkg.sv
`default_nettype none

`include "vdf_consts.svh"

package vdf_pkg;

    typedef logic [`LIMB_BITS-1:0] limb_t;

    // Residue, limb 0 is least significant
    typedef limb_t [`NUM_LIMBS-1:0] operand_t;

    // Full square before reduction
    typedef limb_t [2*`NUM_LIMBS-1:0] product_t;

    typedef logic [`COUNT_BITS-1:0] loop_count_t;

    typedef enum logic [1:0] {
        idle,
        calc,      // Squarer output is captured
        reduce,    // Folded residue is written back
        done
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: verilog/limb_square_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "vdf_consts.svh"

module limb_square_array import vdf_pkg::*; (
    input  operand_t operand,
    output product_t product
);

    localparam int NUM_COLS   = 2 * `NUM_LIMBS - 1;
    localparam int NUM_MULS   = (`NUM_LIMBS + 1) / 2;   // Most distinct pairs in one column
    localparam int PP_BITS    = 2 * `LIMB_BITS;
    localparam int COL_BITS   = PP_BITS + $clog2(`NUM_LIMBS);
    localparam int ACC_BITS   = COL_BITS + 1;
    localparam int CARRY_BITS = ACC_BITS - `LIMB_BITS;

    limb_t                 sel_a   [NUM_COLS][NUM_MULS];
    limb_t                 sel_b   [NUM_COLS][NUM_MULS];
    logic                  sel_dup [NUM_COLS][NUM_MULS];   // Off-diagonal pair
    logic [PP_BITS-1:0]    pp      [NUM_COLS][NUM_MULS];
    logic [COL_BITS-1:0]   pp_grid [NUM_COLS][2*NUM_MULS];
    logic [COL_BITS-1:0]   col_sum [NUM_COLS];
    logic [ACC_BITS-1:0]   acc;
    logic [CARRY_BITS-1:0] carry;

    // Pair selection, only pairs with i <= j so each product is formed once
    for (genvar c = 0; c < NUM_COLS; c++) begin : g_col
        localparam int FIRST     = (c >= `NUM_LIMBS) ? c - `NUM_LIMBS + 1 : 0;
        localparam int NUM_PAIRS = c / 2 - FIRST + 1;

        for (genvar m = 0; m < NUM_MULS; m++) begin : g_pair
            if (m < NUM_PAIRS) begin : g_used
                localparam int IA = FIRST + m;
                localparam int IB = c - IA;

                assign sel_a[c][m]   = operand[IA];
                assign sel_b[c][m]   = operand[IB];
                assign sel_dup[c][m] = (IA != IB);
            end else begin : g_unused
                assign sel_a[c][m]   = '0;
                assign sel_b[c][m]   = '0;
                assign sel_dup[c][m] = 1'b0;
            end
        end
    end

    always_comb begin
        for (int c = 0; c < NUM_COLS; c++) begin
            for (int m = 0; m < NUM_MULS; m++) begin
                pp[c][m] = PP_BITS'(sel_a[c][m]) * PP_BITS'(sel_b[c][m]);
            end
        end
    end

    // a_i*a_j and a_j*a_i land in the same column, so the grid repeats them
    always_comb begin
        for (int c = 0; c < NUM_COLS; c++) begin
            for (int m = 0; m < NUM_MULS; m++) begin
                pp_grid[c][2*m]   = COL_BITS'(pp[c][m]);
                pp_grid[c][2*m+1] = sel_dup[c][m] ? COL_BITS'(pp[c][m]) : '0;
            end
        end
    end

    always_comb begin
        for (int c = 0; c < NUM_COLS; c++) begin
            col_sum[c] = '0;
            for (int g = 0; g < 2 * NUM_MULS; g++) begin
                col_sum[c] = col_sum[c] + pp_grid[c][g];
            end
        end
    end

    // Ripple the column overflow into the next limb
    always_comb begin
        carry = '0;
        acc   = '0;
        for (int c = 0; c < NUM_COLS; c++) begin
            acc        = {1'b0, col_sum[c]} + ACC_BITS'(carry);
            product[c] = acc[`LIMB_BITS-1:0];
            carry      = acc[ACC_BITS-1:`LIMB_BITS];
        end
        product[2*`NUM_LIMBS-1] = carry[`LIMB_BITS-1:0];   // Square fits, upper carry is zero
    end

endmodule

`default_nettype wire

// File: verilog/pseudo_mersenne_reduce.sv
`timescale 1ns/1ns
`default_nettype none

`include "vdf_consts.svh"

module pseudo_mersenne_reduce import vdf_pkg::*; (
    input  product_t product,
    output operand_t reduced
);

    localparam int C_BITS     = $clog2(`FOLD_C + 1);
    localparam int FOLD1_BITS = `OPERAND_BITS + C_BITS + 1;
    localparam int OVF_BITS   = FOLD1_BITS - `OPERAND_BITS;
    localparam int FOLD2_BITS = `OPERAND_BITS + 1;

    localparam logic [FOLD1_BITS-1:0] FOLD_C_WIDE = FOLD1_BITS'(`FOLD_C);
    localparam logic [FOLD2_BITS-1:0] FOLD_C_SMALL = FOLD2_BITS'(`FOLD_C);
    localparam logic [FOLD2_BITS-1:0] MOD_P_WIDE = FOLD2_BITS'(`MOD_P);

    logic [`OPERAND_BITS-1:0] prod_hi;
    logic [`OPERAND_BITS-1:0] prod_lo;
    logic [FOLD1_BITS-1:0]    fold1;
    logic [OVF_BITS-1:0]      ovf;
    logic [FOLD2_BITS-1:0]    fold2;
    logic [FOLD2_BITS-1:0]    diff;
    logic                     ge_p;

    assign prod_hi = product[2*`NUM_LIMBS-1:`NUM_LIMBS];
    assign prod_lo = product[`NUM_LIMBS-1:0];

    // First fold leaves at most a few bits above 2^64
    assign fold1 = FOLD1_BITS'(prod_hi) * FOLD_C_WIDE + FOLD1_BITS'(prod_lo);
    assign ovf   = fold1[FOLD1_BITS-1:`OPERAND_BITS];

    // Second fold, result is below 2^64 + 2^13
    assign fold2 = FOLD2_BITS'(fold1[`OPERAND_BITS-1:0]) + FOLD2_BITS'(ovf) * FOLD_C_SMALL;

    // One subtract is enough to land in [0, P)
    assign diff    = fold2 - MOD_P_WIDE;
    assign ge_p    = (fold2 >= MOD_P_WIDE);
    assign reduced = ge_p ? diff[`OPERAND_BITS-1:0] : fold2[`OPERAND_BITS-1:0];

    // Canonical for any 128-bit input, not just true squares
    always_comb begin
        assert final ($isunknown(reduced) || reduced < `MOD_P)
            else $error("reduced value not below modulus");
    end

endmodule

`default_nettype wire

// File: verilog/square_loop_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "vdf_consts.svh"

module square_loop_ctrl import vdf_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  operand_t    sq_in,
    input  loop_count_t loops,
    input  operand_t    reduced,
    output operand_t    operand,
    output logic        calc_en,
    output logic        valid,
    output logic        busy
);

    ctrl_state_e state;
    ctrl_state_e state_next;
    loop_count_t remaining;   // Squarings still to run
    logic        start_accept;

    assign busy         = (state == calc) || (state == reduce);
    assign valid        = (state == done);
    assign calc_en      = (state == calc);
    assign start_accept = start && !busy;

    always_comb begin
        state_next = state;
        case (state)
            idle, done: begin
                if (start) begin
                    state_next = (loops == '0) ? done : calc;
                end else begin
                    state_next = idle;
                end
            end
            calc: begin
                state_next = reduce;
            end
            reduce: begin
                state_next = (remaining == loop_count_t'(1)) ? done : calc;
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= idle;
            remaining <= '0;
            operand   <= '0;
        end else begin
            state <= state_next;
            if (start_accept) begin
                remaining <= loops;
                operand   <= sq_in;
            end else if (state == reduce) begin
                remaining <= remaining - loop_count_t'(1);
                operand   <= reduced;   // Next iteration squares this
            end
        end
    end

    // Loaded operand and every written-back residue stay canonical
    operand_canonical: assert property (
        @(posedge clk) disable iff (reset)
        busy |-> operand < `MOD_P
    ) else $error("operand not below modulus while busy");

endmodule

`default_nettype wire

// File: verilog/modular_square_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "vdf_consts.svh"

module modular_square_top import vdf_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  operand_t    sq_in,
    input  loop_count_t loops,
    output logic        valid,
    output logic        busy,
    output operand_t    sq_out
);

    operand_t operand;
    operand_t reduced;
    product_t square;
    product_t product_reg;   // Square of the current operand
    logic     calc_en;

    square_loop_ctrl square_loop_ctrl_inst (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .sq_in   (sq_in),
        .loops   (loops),
        .reduced (reduced),
        .operand (operand),
        .calc_en (calc_en),
        .valid   (valid),
        .busy    (busy)
    );

    limb_square_array limb_square_array_inst (
        .operand (operand),
        .product (square)
    );

    // Splits the loop into a square cycle and a fold cycle
    always_ff @(posedge clk) begin
        if (calc_en) begin
            product_reg <= square;
        end
    end

    pseudo_mersenne_reduce pseudo_mersenne_reduce_inst (
        .product (product_reg),
        .reduced (reduced)
    );

    assign sq_out = operand;   // Held from valid until the next accepted start

endmodule

`default_nettype wire

// File: verif/modular_square_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "vdf_consts.svh"

module modular_square_tb import vdf_pkg::*; ();

    typedef struct packed {
        operand_t    expected;
        loop_count_t loops;
        logic [31:0] issued;   // Cycle count when start was driven
    } job_t;

    logic        clk;
    logic        reset;
    logic        start;
    operand_t    sq_in;
    loop_count_t loops;
    logic        valid;
    logic        busy;
    operand_t    sq_out;

    job_t        job_q[$];   // Accepted jobs still waiting for valid
    int unsigned cycle_count = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_mark = 0;
    integer      seed;

    modular_square_top modular_square_top_inst (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .sq_in  (sq_in),
        .loops  (loops),
        .valid  (valid),
        .busy   (busy),
        .sq_out (sq_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // x^(2^t) mod P by plain 128-bit arithmetic
    function automatic operand_t chained_square(input operand_t x, input loop_count_t t);
        logic [127:0] acc;
        acc = {64'd0, x};
        for (int i = 0; i < int'(t); i++) begin
            acc = (acc * acc) % {64'd0, `MOD_P};
        end
        return acc[63:0];
    endfunction

    initial begin : compare_results
        job_t job;
        forever begin
            @(negedge clk);
            if (!reset && valid === 1'b1) begin
                if (job_q.size() == 0) begin
                    $display("Valid pulse at %0t with no job pending", $time);
                    errors++;
                end else begin
                    job = job_q.pop_front();
                    checks++;
                    assert (sq_out == job.expected) else begin
                        $display("ERR %0t: sq_out %h, expected %h (loops %0d)",
                                 $time, sq_out, job.expected, job.loops);
                        errors++;
                    end
                    assert (busy == 1'b0) else begin
                        $display("ERR %0t: busy still high with valid", $time);
                        errors++;
                    end
                    // Latency from the edge that sampled start
                    assert (cycle_count - job.issued == 2 * 32'(job.loops) + 32'd1) else begin
                        $display("ERR %0t: valid after %0d cycles, expected %0d", $time,
                                 cycle_count - job.issued, 2 * 32'(job.loops) + 32'd1);
                        errors++;
                    end
                end
            end
        end
    end

    task automatic issue_start(input operand_t x, input loop_count_t n);
        job_t job;
        @(posedge clk);
        #1;
        start = 1'b1;
        sq_in = x;
        loops = n;
        job.expected = chained_square(x, n);
        job.loops    = n;
        job.issued   = cycle_count;
        job_q.push_back(job);
        @(posedge clk);
        #1;
        start = 1'b0;
        @(negedge clk);
        assert (busy == (n != '0)) else begin
            $display("ERR %0t: busy %b right after start with loops %0d", $time, busy, n);
            errors++;
        end
    endtask

    task automatic wait_result(input loop_count_t n);
        int limit;
        int waited;
        limit  = 2 * int'(n) + 20;
        waited = 0;
        while (job_q.size() != 0 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (job_q.size() != 0) begin
            $display("Timeout at %0t: valid never came within %0d cycles", $time, limit);
            errors++;
            job_q.delete();
        end
    endtask

    task automatic run_job(input operand_t x, input loop_count_t n);
        issue_start(x, n);
        wait_result(n);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_mark) begin
            $display("Test %0d, %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d, %s: FAIL with %0d errors", tests_run, name, errors - test_mark);
        end
        test_mark = errors;
    endtask

    initial begin : stimulus
        operand_t    x;
        operand_t    y;
        operand_t    held;
        loop_count_t n;
        logic [63:0] rnd;
        operand_t    edge_ops [5];
        reset = 1'b1;
        start = 1'b0;
        sq_in = '0;
        loops = '0;
        seed  = 90;
        edge_ops = '{64'd0, 64'd1, 64'd2, `MOD_P - 64'd1, 64'h8000_0000_0000_0000};

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        foreach (edge_ops[i]) begin
            run_job(edge_ops[i], loop_count_t'(1));
        end
        end_test("one squaring of edge operands");

        for (int i = 0; i < 20; i++) begin
            rnd = {$random(seed), $random(seed)};
            x   = rnd % `MOD_P;
            n   = loop_count_t'(1 + ($unsigned($random(seed)) % 20));
            run_job(x, n);
        end
        end_test("random operands and loop counts");

        rnd = {$random(seed), $random(seed)};
        x   = rnd % `MOD_P;
        run_job(x, loop_count_t'(3));
        run_job(x, loop_count_t'(10));
        end_test("latency for 3 and 10 loops");

        run_job(64'h0123_4567_89AB_CDEF, '0);
        run_job(`MOD_P - 64'd1, '0);
        end_test("zero loops returns the input");

        rnd = {$random(seed), $random(seed)};
        x   = rnd % `MOD_P;
        y   = x ^ 64'h00FF_00FF_00FF_00FF;   // Differs from x in every limb
        issue_start(x, loop_count_t'(6));
        repeat (2) @(posedge clk);
        #1;
        start = 1'b1;
        sq_in = y;
        loops = loop_count_t'(2);
        @(posedge clk);
        #1;
        start = 1'b0;
        wait_result(loop_count_t'(6));
        held = chained_square(x, loop_count_t'(6));
        repeat (10) @(negedge clk);
        assert (sq_out == held) else begin
            $display("ERR %0t: sq_out %h not held at %h", $time, sq_out, held);
            errors++;
        end
        end_test("start ignored while busy");

        issue_start(64'h0000_0000_DEAD_BEEF, loop_count_t'(10));
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        assert (!valid && !busy && sq_out == '0) else begin
            $display("ERR %0t: after reset valid %b busy %b sq_out %h", $time, valid, busy,
                     sq_out);
            errors++;
        end
        job_q.delete();   // The interrupted job never completes
        @(posedge clk);
        #1;
        reset = 1'b0;
        run_job(64'h1234_5678_9ABC_DEF0, loop_count_t'(5));
        end_test("reset in the middle of a run");

        $display("Summary: %0d tests, %0d failed, %0d results checked, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+verilog
verilog/vdf_pkg.sv
verilog/limb_square_array.sv
verilog/pseudo_mersenne_reduce.sv
verilog/square_loop_ctrl.sv
verilog/modular_square_top.sv
verif/modular_square_tb.sv

// File: Makefile
TOP = modular_square_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Test failures found" sim.log; then \
		echo "Simulation reported failures"; exit 1; \
	fi
	@if ! grep -q "All tests passed!" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir sim.log
